//--- source/cart_bus_pkg.sv
package cart_bus_pkg;

    // Console multiplexed AD bus
    localparam int ad_width = 16;

    // Full host address after both ALE phases
    localparam int addr_width = 32;

    // Wishbone word address, byte address bits 24 down to 1
    localparam int wb_addr_width = 24;

    // Access sequencing in the PI controller
    typedef enum logic [2:0] {
        idle,
        addr_wait,
        prefetch,
        ready,
        read_out,
        write_wb,
        reg_access
    } ctrl_state_t;

endpackage

//--- source/cart_map_pkg.sv
package cart_map_pkg;

    // Cartridge ROM, read only
    localparam logic [31:0] rom_base = 32'h1000_0000;
    localparam logic [31:0] rom_limit = 32'h13FF_FFFF;

    // Save memory, read and write
    localparam logic [31:0] save_base = 32'h0800_0000;
    localparam logic [31:0] save_limit = 32'h0801_FFFF;

    // Configuration block, 16 bytes
    localparam logic [31:0] cfg_base = 32'h1FFF_0000;

    // Register byte offsets inside the configuration block
    localparam logic [3:0] reg_id = 4'h0;
    localparam logic [3:0] reg_scratch = 4'h2;
    localparam logic [3:0] reg_save_count = 4'h4;
    localparam logic [3:0] reg_irq_delay = 4'h6;
    localparam logic [3:0] reg_status = 4'h8;

    // Value returned at reg_id
    localparam logic [15:0] cart_id = 16'h4341;

endpackage

//--- source/pi_addr_latch.sv
`timescale 1ns/1ps

module pi_addr_latch (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                latch_hi,
    input  logic                                latch_lo,
    input  logic                                advance,
    input  logic [cart_bus_pkg::ad_width-1:0]   ad_sync,
    output logic [cart_bus_pkg::addr_width-1:0] addr
);

    import cart_bus_pkg::*;

    // Halfword step per completed data cycle
    localparam logic [addr_width-1:0] addr_step = addr_width'(2);

    always_ff @(posedge clk) begin
        if (rst) begin
            addr <= '0;
        end else if (latch_hi) begin
            addr[addr_width-1:ad_width] <= ad_sync;
        end else if (latch_lo) begin
            addr[ad_width-1:0] <= ad_sync;
        end else if (advance) begin
            // Carry runs into the upper half like the console counter
            addr <= addr + addr_step;
        end
    end

    // The controller must never finish a data cycle during an address phase
    assert property (@(posedge clk) disable iff (rst) !(advance && latch_lo))
        else $error("advance overlaps latch_lo");

endmodule

//--- source/cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              reg_stb,
    input  logic                              reg_we,
    input  logic [3:0]                        reg_offset,
    input  logic [cart_bus_pkg::ad_width-1:0] reg_wdata,
    output logic [cart_bus_pkg::ad_width-1:0] reg_rdata,
    input  logic                              save_write_done,
    output logic                              irq
);

    import cart_bus_pkg::*;
    import cart_map_pkg::*;

    logic [ad_width-1:0] scratch_q;
    logic [ad_width-1:0] save_count_q;
    logic [ad_width-1:0] delay_cnt_q;
    logic                running_q;
    logic                pending_q;
    logic                reg_wr;

    assign reg_wr = reg_stb && reg_we;

    always_ff @(posedge clk) begin
        if (reg_wr && reg_offset == reg_scratch) begin
            scratch_q <= reg_wdata;
        end
    end

    // Completed save writes, saturating
    always_ff @(posedge clk) begin
        if (rst) begin
            save_count_q <= '0;
        end else if (reg_wr && reg_offset == reg_save_count) begin
            save_count_q <= '0;
        end else if (save_write_done && save_count_q != '1) begin
            save_count_q <= save_count_q + 1'b1;
        end
    end

    // Interrupt countdown and pending flag
    always_ff @(posedge clk) begin
        if (rst) begin
            delay_cnt_q <= '0;
            running_q   <= 1'b0;
            pending_q   <= 1'b0;
        end else begin
            if (reg_wr && reg_offset == reg_irq_delay) begin
                delay_cnt_q <= reg_wdata;
                // Zero cancels a running countdown
                running_q   <= reg_wdata != '0;
            end else if (running_q) begin
                delay_cnt_q <= delay_cnt_q - 1'b1;
                if (delay_cnt_q == ad_width'(1)) begin
                    running_q <= 1'b0;
                    pending_q <= 1'b1;
                end
            end

            if (reg_wr && reg_offset == reg_status && reg_wdata[0]) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irq <= 1'b0;
        end else begin
            irq <= pending_q;
        end
    end

    always_comb begin
        case (reg_offset)
            reg_id:         reg_rdata = cart_id;
            reg_scratch:    reg_rdata = scratch_q;
            reg_save_count: reg_rdata = save_count_q;
            reg_status:     reg_rdata = {{(ad_width - 2){1'b0}}, running_q, pending_q};
            default:        reg_rdata = '0;
        endcase
    end

    // Register accesses and save acknowledges come from exclusive controller states
    assert property (@(posedge clk) disable iff (rst) !(reg_stb && save_write_done))
        else $error("reg_stb overlaps save_write_done");

endmodule

//--- source/pi_ctrl.sv
`timescale 1ns/1ps

module pi_ctrl (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   ale_h,
    input  logic                                   ale_l,
    input  logic                                   read_n,
    input  logic                                   write_n,
    input  logic [cart_bus_pkg::ad_width-1:0]      ad_in,
    output logic [cart_bus_pkg::ad_width-1:0]      ad_out,
    output logic                                   ad_oe,
    output logic                                   latch_hi,
    output logic                                   latch_lo,
    output logic                                   advance,
    output logic [cart_bus_pkg::ad_width-1:0]      ad_sync,
    input  logic [cart_bus_pkg::addr_width-1:0]    addr,
    output logic                                   reg_stb,
    output logic                                   reg_we,
    output logic [3:0]                             reg_offset,
    output logic [cart_bus_pkg::ad_width-1:0]      reg_wdata,
    input  logic [cart_bus_pkg::ad_width-1:0]      reg_rdata,
    output logic                                   save_write_done,
    output logic                                   wb_cyc,
    output logic                                   wb_stb,
    output logic                                   wb_we,
    output logic [cart_bus_pkg::wb_addr_width-1:0] wb_adr,
    output logic [cart_bus_pkg::ad_width-1:0]      wb_dat_w,
    output logic [1:0]                             wb_sel,
    input  logic [cart_bus_pkg::ad_width-1:0]      wb_dat_r,
    input  logic                                   wb_ack
);

    import cart_bus_pkg::*;
    import cart_map_pkg::*;

    // Two sync stages, the third one holds the previous level
    logic [2:0]               aleh_s;
    logic [2:0]               alel_s;
    logic [2:0]               rd_s;
    logic [2:0]               wr_s;
    logic [2:0][ad_width-1:0] ad_s;

    logic        hi_fall;
    logic        lo_fall;
    logic        rd_fall;
    logic        rd_rise;
    logic        wr_rise;
    logic        in_rom;
    logic        in_save;
    logic        in_cfg;
    logic        in_mem;
    logic        rd_pend;
    ctrl_state_t state;

    logic [ad_width-1:0] data_q;
    logic [ad_width-1:0] wdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            aleh_s <= '0;
            alel_s <= '0;
            rd_s   <= '1;
            wr_s   <= '1;
        end else begin
            aleh_s <= {aleh_s[1:0], ale_h};
            alel_s <= {alel_s[1:0], ale_l};
            rd_s   <= {rd_s[1:0], read_n};
            wr_s   <= {wr_s[1:0], write_n};
        end
    end

    always_ff @(posedge clk) begin
        ad_s <= {ad_s[1:0], ad_in};
    end

    // ad_s[2] is the bus value from just before the detected edge
    assign ad_sync = ad_s[2];

    assign hi_fall = aleh_s[2] && !aleh_s[1];
    assign lo_fall = alel_s[2] && !alel_s[1];
    assign rd_fall = rd_s[2] && !rd_s[1];
    assign rd_rise = !rd_s[2] && rd_s[1];
    assign wr_rise = !wr_s[2] && wr_s[1];

    assign latch_hi = hi_fall;
    assign latch_lo = lo_fall;

    assign in_rom  = addr >= rom_base && addr <= rom_limit;
    assign in_save = addr >= save_base && addr <= save_limit;
    assign in_cfg  = addr[31:4] == cfg_base[31:4];
    assign in_mem  = in_rom || in_save;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            wb_cyc  <= 1'b0;
            wb_stb  <= 1'b0;
            wb_we   <= 1'b0;
            reg_stb <= 1'b0;
            reg_we  <= 1'b0;
            ad_oe   <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (lo_fall) begin
                        state <= addr_wait;
                    end
                end
                addr_wait: begin
                    if (in_mem) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        state  <= prefetch;
                    end else begin
                        state <= ready;
                    end
                end
                prefetch: begin
                    // Slow memory, the read strobe may already be down
                    if (rd_fall) begin
                        rd_pend <= 1'b1;
                    end
                    if (wb_ack) begin
                        wb_cyc  <= 1'b0;
                        wb_stb  <= 1'b0;
                        rd_pend <= 1'b0;
                        if (rd_pend || rd_fall) begin
                            ad_oe <= 1'b1;
                            state <= read_out;
                        end else begin
                            state <= ready;
                        end
                    end
                end
                ready: begin
                    if (rd_fall) begin
                        if (in_mem) begin
                            ad_oe <= 1'b1;
                            state <= read_out;
                        end else begin
                            reg_stb <= in_cfg;
                            reg_we  <= 1'b0;
                            state   <= reg_access;
                        end
                    end else if (wr_rise) begin
                        if (in_save) begin
                            wb_cyc <= 1'b1;
                            wb_stb <= 1'b1;
                            wb_we  <= 1'b1;
                            state  <= write_wb;
                        end else begin
                            // ROM and unmapped writes only step the address
                            reg_stb <= in_cfg;
                            reg_we  <= 1'b1;
                            state   <= reg_access;
                        end
                    end else if (lo_fall) begin
                        state <= addr_wait;
                    end
                end
                read_out: begin
                    if (rd_rise) begin
                        ad_oe <= 1'b0;
                        state <= addr_wait;
                    end
                end
                write_wb: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        state  <= addr_wait;
                    end
                end
                reg_access: begin
                    reg_stb <= 1'b0;
                    if (reg_we) begin
                        state <= addr_wait;
                    end else begin
                        ad_oe <= 1'b1;
                        state <= read_out;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == prefetch && wb_ack) begin
            data_q <= wb_dat_r;
        end else if (state == reg_access && !reg_we) begin
            data_q <= in_cfg ? reg_rdata : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_rise) begin
            wdata_q <= ad_sync;
        end
    end

    assign advance = (state == read_out && rd_rise) || (state == write_wb && wb_ack)
                     || (state == reg_access && reg_we);
    assign save_write_done = state == write_wb && wb_ack;

    assign ad_out     = data_q;
    assign reg_offset = addr[3:0];
    assign reg_wdata  = wdata_q;
    assign wb_adr     = addr[wb_addr_width:1];
    assign wb_dat_w   = wdata_q;
    assign wb_sel     = 2'b11;

    assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("wb_stb without wb_cyc");

    // Address and direction hold until the slave acknowledges
    assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we))
        else $error("Wishbone request changed before ack");

    // Four high samples of read_n cover the synchronizer and the release delay
    assert property (@(posedge clk) disable iff (rst) read_n && (&rd_s) |-> !ad_oe)
        else $error("ad_oe high with no read strobe");

    assert property (@(posedge clk) disable iff (rst) wb_cyc && wb_we |-> !in_rom)
        else $error("Wishbone write to ROM");

endmodule

//--- source/cart_top.sv
`timescale 1ns/1ps

module cart_top (
    input  logic                                   clk,
    input  logic                                   rst,

    input  logic                                   ale_h,
    input  logic                                   ale_l,
    input  logic                                   read_n,
    input  logic                                   write_n,
    input  logic [cart_bus_pkg::ad_width-1:0]      ad_in,
    output logic [cart_bus_pkg::ad_width-1:0]      ad_out,
    output logic                                   ad_oe,
    output logic                                   irq,

    output logic                                   wb_cyc,
    output logic                                   wb_stb,
    output logic                                   wb_we,
    output logic [cart_bus_pkg::wb_addr_width-1:0] wb_adr,
    output logic [cart_bus_pkg::ad_width-1:0]      wb_dat_w,
    output logic [1:0]                             wb_sel,
    input  logic [cart_bus_pkg::ad_width-1:0]      wb_dat_r,
    input  logic                                   wb_ack
);

    import cart_bus_pkg::*;

    logic                  latch_hi;
    logic                  latch_lo;
    logic                  advance;
    logic [ad_width-1:0]   ad_sync;
    logic [addr_width-1:0] addr;
    logic                  reg_stb;
    logic                  reg_we;
    logic [3:0]            reg_offset;
    logic [ad_width-1:0]   reg_wdata;
    logic [ad_width-1:0]   reg_rdata;
    logic                  save_write_done;

    pi_ctrl ctrl_i (
        .clk(clk),
        .rst(rst),

        .ale_h(ale_h),
        .ale_l(ale_l),
        .read_n(read_n),
        .write_n(write_n),
        .ad_in(ad_in),
        .ad_out(ad_out),
        .ad_oe(ad_oe),

        .latch_hi(latch_hi),
        .latch_lo(latch_lo),
        .advance(advance),
        .ad_sync(ad_sync),
        .addr(addr),

        .reg_stb(reg_stb),
        .reg_we(reg_we),
        .reg_offset(reg_offset),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .save_write_done(save_write_done),

        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_sel(wb_sel),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

    pi_addr_latch addr_i (
        .clk(clk),
        .rst(rst),
        .latch_hi(latch_hi),
        .latch_lo(latch_lo),
        .advance(advance),
        .ad_sync(ad_sync),
        .addr(addr)
    );

    cfg_regs regs_i (
        .clk(clk),
        .rst(rst),
        .reg_stb(reg_stb),
        .reg_we(reg_we),
        .reg_offset(reg_offset),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .save_write_done(save_write_done),
        .irq(irq)
    );

endmodule

//--- tests/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [23:0] wb_adr,
    input  logic [15:0] wb_dat_w,
    input  logic [1:0]  wb_sel,
    output logic [15:0] wb_dat_r,
    output logic        wb_ack
);

    logic [15:0] mem [0:65535];
    logic [2:0]  wait_cnt = 3'd0;
    logic        busy = 1'b0;
    logic        ack_q = 1'b0;
    logic [15:0] rdata_q = 16'h0000;
    bit          seeded = 1'b0;

    // Each word starts as its own index XOR a fixed pattern
    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 16'(i) ^ 16'hA5A5;
        end
    end

    assign wb_ack   = ack_q;
    assign wb_dat_r = rdata_q;

    always @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            busy  <= 1'b0;
            if (!seeded) begin
                void'($urandom(32'h43e7));
                seeded <= 1'b1;
            end
        end else begin
            ack_q <= 1'b0;
            if (wb_cyc && wb_stb && !ack_q) begin
                if (!busy) begin
                    // Ack lands 1 to 4 cycles after the request is first seen
                    busy     <= 1'b1;
                    wait_cnt <= 3'($urandom_range(3, 0));
                end else if (wait_cnt == 3'd0) begin
                    busy    <= 1'b0;
                    ack_q   <= 1'b1;
                    rdata_q <= mem[wb_adr[15:0]];
                    if (wb_we && wb_sel[0]) begin
                        mem[wb_adr[15:0]][7:0] = wb_dat_w[7:0];
                    end
                    if (wb_we && wb_sel[1]) begin
                        mem[wb_adr[15:0]][15:8] = wb_dat_w[15:8];
                    end
                end else begin
                    wait_cnt <= wait_cnt - 3'd1;
                end
            end else begin
                busy <= 1'b0;
            end
        end
    end

endmodule

//--- tests/cart_tb.sv
`timescale 1ns/1ps

module cart_tb;

    typedef enum logic [1:0] {
        op_read,
        op_write,
        op_irq
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [15:0] data;
        logic [15:0] exp;
    } entry_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        ale_h;
    logic        ale_l;
    logic        read_n;
    logic        write_n;
    logic [15:0] ad_in;
    logic [15:0] ad_out;
    logic        ad_oe;
    logic        irq;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [23:0] wb_adr;
    logic [15:0] wb_dat_w;
    logic [1:0]  wb_sel;
    logic [15:0] wb_dat_r;
    logic        wb_ack;

    entry_t      steps [$];
    entry_t      cur;
    logic [31:0] host_addr;
    logic [15:0] rd_data;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    always #50 clk = ~clk;

    cart_top dut_i (
        .clk(clk), .rst(rst),
        .ale_h(ale_h), .ale_l(ale_l), .read_n(read_n), .write_n(write_n),
        .ad_in(ad_in), .ad_out(ad_out), .ad_oe(ad_oe), .irq(irq),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    wb_mem_model mem_i (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the stimulus table did not finish in %0d cycles", cycle_limit);
            $display("Done: errors found");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task stop_on_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "first failing check ends the run");
    endtask

    task add_step(input op_t op, input logic [31:0] addr,
                  input logic [15:0] data, input logic [15:0] exp);
        entry_t e;
        e.op   = op;
        e.addr = addr;
        e.data = data;
        e.exp  = exp;
        steps.push_back(e);
    endtask

    // Idle bus, ad_oe must drop once the read hold window has passed
    task bus_gap;
        int i;
        for (i = 0; i < 12; i++) begin
            @(negedge clk);
            if (i >= 4) begin
                assert (!ad_oe) else stop_on_error("ad_oe high with no read strobe");
            end
        end
    endtask

    task address_phase(input logic [31:0] a);
        @(posedge clk);
        ale_h <= 1'b1;
        ale_l <= 1'b1;
        ad_in <= a[31:16];
        repeat (6) @(posedge clk);
        ale_h <= 1'b0;
        ad_in <= a[15:0];
        repeat (6) @(posedge clk);
        ale_l <= 1'b0;
        bus_gap();
    endtask

    task host_read(output logic [15:0] data);
        @(posedge clk);
        read_n <= 1'b0;
        repeat (19) @(posedge clk);
        @(negedge clk);
        assert (ad_oe) else stop_on_error("ad_oe low at the end of the read strobe");
        data = ad_out;
        @(posedge clk);
        read_n <= 1'b1;
        bus_gap();
    endtask

    task host_write(input logic [15:0] data);
        @(posedge clk);
        write_n <= 1'b0;
        ad_in   <= data;
        repeat (8) @(posedge clk);
        write_n <= 1'b1;
        bus_gap();
    endtask

    task wait_irq(input int n);
        int waited;
        waited = 0;
        while (!irq && waited < n + 20) begin
            @(negedge clk);
            waited++;
        end
        assert (waited >= n - 20) else stop_on_error("irq rose before the countdown ended");
        assert (irq) else stop_on_error($sformatf("irq still low after %0d cycles", waited));
        repeat (5) begin
            @(negedge clk);
            assert (irq) else stop_on_error("irq dropped while still pending");
        end
    endtask

    task build_table;
        // Four ROM words from one address phase, word index 0x918 upward
        add_step(op_read, 32'h1000_1230, 16'h0000, 16'hACBD);
        add_step(op_read, 32'h1000_1232, 16'h0000, 16'hACBC);
        add_step(op_read, 32'h1000_1234, 16'h0000, 16'hACBF);
        add_step(op_read, 32'h1000_1236, 16'h0000, 16'hACBE);
        add_step(op_write, 32'h0800_4000, 16'h1357, 16'h0000);
        add_step(op_write, 32'h0800_4002, 16'h2468, 16'h0000);
        add_step(op_read, 32'h0800_4000, 16'h0000, 16'h1357);
        add_step(op_read, 32'h0800_4002, 16'h0000, 16'h2468);
        // ROM write is dropped, word 0x1000 keeps its preload
        add_step(op_write, 32'h1000_2000, 16'hDEAD, 16'h0000);
        add_step(op_read, 32'h1000_2000, 16'h0000, 16'hB5A5);
        add_step(op_read, 32'h1FFF_0000, 16'h0000, 16'h4341);
        add_step(op_write, 32'h1FFF_0002, 16'h5AA5, 16'h0000);
        add_step(op_read, 32'h1FFF_0002, 16'h0000, 16'h5AA5);
        add_step(op_read, 32'h1FFF_0004, 16'h0000, 16'h0002);
        add_step(op_write, 32'h1FFF_0004, 16'h0000, 16'h0000);
        add_step(op_read, 32'h1FFF_0004, 16'h0000, 16'h0000);
        add_step(op_read, 32'h0600_0010, 16'h0000, 16'h0000);
        add_step(op_write, 32'h1FFF_0006, 16'd40, 16'h0000);
        add_step(op_irq, 32'h0000_0000, 16'd40, 16'h0000);
        add_step(op_write, 32'h1FFF_0008, 16'h0001, 16'h0000);
        add_step(op_read, 32'h1FFF_0008, 16'h0000, 16'h0000);
    endtask

    initial begin
        rst     <= 1'b1;
        ale_h   <= 1'b0;
        ale_l   <= 1'b0;
        read_n  <= 1'b1;
        write_n <= 1'b1;
        ad_in   <= 16'h0000;
        build_table();
        cycle_limit = steps.size() * 80 + 200;
        host_addr   = 32'hFFFF_FFFF;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < steps.size(); i++) begin
            cur = steps[i];
            // A new address phase only when the host address does not run on
            if (cur.op != op_irq && cur.addr != host_addr) begin
                address_phase(cur.addr);
                host_addr = cur.addr;
            end
            case (cur.op)
                op_read: begin
                    host_read(rd_data);
                    assert (rd_data == cur.exp)
                        else stop_on_error($sformatf("read %08h returned %04h, expected %04h",
                                                     cur.addr, rd_data, cur.exp));
                    assert (!irq) else stop_on_error("irq high with no pending interrupt");
                    host_addr = host_addr + 32'd2;
                end
                op_write: begin
                    host_write(cur.data);
                    host_addr = host_addr + 32'd2;
                end
                default: begin
                    wait_irq(int'(cur.data));
                end
            endcase
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- src.f
source/cart_bus_pkg.sv
source/cart_map_pkg.sv
source/pi_addr_latch.sv
source/cfg_regs.sv
source/pi_ctrl.sv
source/cart_top.sv
tests/wb_mem_model.sv
tests/cart_tb.sv

//--- Makefile
TOP = cart_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f src.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
